// ==== logic/spin_if_pkg.sv ====
// spin interface shared definitions
`default_nettype none

package spin_if_pkg;

    // spins exchanged with the macro
    localparam int NUM_SPIN   = 16;

    // deepest synchronizer tap
    localparam int SYNC_DEPTH = 4;
    localparam int SYNC_SEL_W = 2;

    // configuration counter widths
    localparam int CMPT_CNT_W = 8;
    localparam int ITER_CNT_W = 4;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    // value k selects k+1 stages
    typedef logic [SYNC_SEL_W-1:0] sync_sel_t;

    // compute window length in clock cycles
    typedef logic [CMPT_CNT_W-1:0] cmpt_cnt_t;

    // zero behaves as a single iteration
    typedef logic [ITER_CNT_W-1:0] iter_cnt_t;

    // iteration sequencer states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOAD,
        CTRL_COMPUTE,
        CTRL_DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/spin_synchronizer.sv ====
// spin capture synchronizer
`default_nettype none

module spin_synchronizer
    import spin_if_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            en_i,
    input  wire spin_vec_t data_i,
    input  wire sync_sel_t sync_sel_i,
    input  wire            sync_en_i,
    output logic           data_valid_o,
    output spin_vec_t      data_o
);

    logic [SYNC_DEPTH-1:0] valid_q;
    spin_vec_t             data_q [SYNC_DEPTH];
    spin_vec_t             tap_data;

    // valid bit walks along with its capture
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !en_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[SYNC_DEPTH-2:0], sync_en_i};
        end
    end

    // stage 0 takes the macro outputs on the capture strobe
    always_ff @(posedge clk_i) begin
        if (sync_en_i) begin
            data_q[0] <= data_i;
        end
    end

    // remaining stages shift every cycle
    always_ff @(posedge clk_i) begin
        for (int i = 1; i < SYNC_DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign tap_data = data_q[sync_sel_i];

    // nothing leaves a disabled synchronizer
    assign data_valid_o = en_i & valid_q[sync_sel_i];

    // isolation forces zeros between captures
    assign data_o = data_valid_o ? tap_data : '0;

endmodule

`default_nettype wire

// ==== logic/analog_tx.sv ====
// analog to digital spin transfer
`default_nettype none

module analog_tx
    import spin_if_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            en_i,
    input  wire            cfg_we_i,
    input  wire sync_sel_t sync_sel_i,
    output sync_sel_t      sync_sel_o,
    input  wire spin_vec_t macro_spin_i,
    input  wire            cmpt_finish_i,
    output logic           spin_valid_o,
    input  wire            spin_ready_i,
    output spin_vec_t      spin_o,
    output logic           idle_o
);

    sync_sel_t sync_sel_q;
    logic      sync_valid;
    spin_vec_t sync_data;
    logic      spin_valid_q;
    spin_vec_t spin_q;
    logic      handshake;

    // tap select defaults to the deepest stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync_sel_q <= '1;
        end else if (en_i && cfg_we_i) begin
            sync_sel_q <= sync_sel_i;
        end
    end

    spin_synchronizer u_sync (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .en_i         (en_i),
        .data_i       (macro_spin_i),
        .sync_sel_i   (sync_sel_q),
        .sync_en_i    (cmpt_finish_i),
        .data_valid_o (sync_valid),
        .data_o       (sync_data)
    );

    assign handshake = spin_valid_q & spin_ready_i;

    // fresh capture beats clearing
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            spin_valid_q <= 1'b0;
        end else if (sync_valid) begin
            spin_valid_q <= 1'b1;
        end else if (!en_i || handshake) begin
            spin_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sync_valid) begin
            spin_q <= sync_data;
        end
    end

    assign spin_valid_o = spin_valid_q;
    assign spin_o       = spin_q;
    assign sync_sel_o   = sync_sel_q;
    assign idle_o       = !spin_valid_q;

endmodule

`default_nettype wire

// ==== logic/analog_rx.sv ====
// digital to analog spin transfer
`default_nettype none

module analog_rx
    import spin_if_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            en_i,
    input  wire            cfg_we_i,
    input  wire cmpt_cnt_t cmpt_cycles_i,
    input  wire            load_i,
    input  wire            load_fb_i,
    input  wire spin_vec_t host_spin_i,
    input  wire spin_vec_t fb_spin_i,
    output spin_vec_t      macro_spin_o,
    output logic           macro_start_o,
    output logic           cmpt_finish_o
);

    cmpt_cnt_t cmpt_cycles_q;
    cmpt_cnt_t cnt_q;
    spin_vec_t macro_spin_q;
    logic      start_q;

    // a zero length window would never finish
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmpt_cycles_q <= cmpt_cnt_t'(1);
        end else if (en_i && cfg_we_i) begin
            cmpt_cycles_q <= (cmpt_cycles_i == '0) ? cmpt_cnt_t'(1) : cmpt_cycles_i;
        end
    end

    // spins held toward the macro until the next load
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            macro_spin_q <= load_fb_i ? fb_spin_i : host_spin_i;
        end
    end

    // start lines up with the registered spins
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !en_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= load_i;
        end
    end

    // finish fires when the window counter reaches one
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !en_i) begin
            cnt_q <= '0;
        end else if (start_q) begin
            cnt_q <= cmpt_cycles_q;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - cmpt_cnt_t'(1);
        end
    end

    assign macro_spin_o  = macro_spin_q;
    assign macro_start_o = start_q;
    assign cmpt_finish_o = (cnt_q == cmpt_cnt_t'(1));

endmodule

`default_nettype wire

// ==== logic/spin_flow_ctrl.sv ====
// iteration sequencer
`default_nettype none

module spin_flow_ctrl
    import spin_if_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            en_i,
    input  wire            cfg_we_i,
    input  wire iter_cnt_t num_iter_i,
    input  wire            start_i,
    input  wire            spin_valid_i,
    output logic           spin_ready_o,
    output logic           load_o,
    output logic           load_fb_o,
    output logic           result_valid_o,
    input  wire            result_ready_i,
    output logic           busy_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    iter_cnt_t   num_iter_q;
    iter_cnt_t   iter_rem_q;
    logic        go;
    logic        last_iter;
    logic        fb_step;
    logic        drain_done;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            num_iter_q <= iter_cnt_t'(1);
        end else if (en_i && cfg_we_i) begin
            num_iter_q <= num_iter_i;
        end
    end

    // start only counts while idle
    assign go         = en_i & start_i & (state_q == CTRL_IDLE);
    assign last_iter  = (iter_rem_q == iter_cnt_t'(1));
    assign fb_step    = en_i & (state_q == CTRL_COMPUTE) & spin_valid_i & !last_iter;
    assign drain_done = (state_q == CTRL_DRAIN) & spin_valid_i & result_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (go) begin
                    state_d = CTRL_LOAD;
                end
            end
            // macro start goes out here
            CTRL_LOAD: begin
                state_d = CTRL_COMPUTE;
            end
            CTRL_COMPUTE: begin
                if (spin_valid_i && last_iter) begin
                    state_d = CTRL_DRAIN;
                end
            end
            CTRL_DRAIN: begin
                if (drain_done) begin
                    state_d = CTRL_IDLE;
                end
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
        if (!en_i) begin
            state_d = CTRL_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // remaining iterations including the one in progress
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            iter_rem_q <= '0;
        end else if (go) begin
            iter_rem_q <= (num_iter_q == '0) ? iter_cnt_t'(1) : num_iter_q;
        end else if (fb_step) begin
            iter_rem_q <= iter_rem_q - iter_cnt_t'(1);
        end
    end

    // host load on start and feedback load on each intermediate result
    assign load_o    = go | fb_step;
    assign load_fb_o = fb_step;

    assign spin_ready_o   = fb_step | ((state_q == CTRL_DRAIN) & result_ready_i);
    assign result_valid_o = (state_q == CTRL_DRAIN) & spin_valid_i;
    assign busy_o         = (state_q != CTRL_IDLE);

endmodule

`default_nettype wire

// ==== logic/spin_if_top.sv ====
// spin transfer interface top
`default_nettype none

module spin_if_top
    import spin_if_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            en_i,
    input  wire            cfg_we_i,
    input  wire sync_sel_t cfg_sync_sel_i,
    input  wire cmpt_cnt_t cfg_cmpt_cycles_i,
    input  wire iter_cnt_t cfg_num_iter_i,
    output sync_sel_t      sync_sel_o,
    input  wire            start_i,
    input  wire spin_vec_t host_spin_i,
    output logic           busy_o,
    output logic           result_valid_o,
    input  wire            result_ready_i,
    output spin_vec_t      result_spin_o,
    output spin_vec_t      macro_spin_o,
    output logic           macro_start_o,
    input  wire spin_vec_t macro_spin_i,
    output logic           idle_o
);

    logic load;
    logic load_fb;
    logic spin_valid;
    logic spin_ready;
    logic cmpt_finish;

    spin_flow_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (en_i),
        .cfg_we_i       (cfg_we_i),
        .num_iter_i     (cfg_num_iter_i),
        .start_i        (start_i),
        .spin_valid_i   (spin_valid),
        .spin_ready_o   (spin_ready),
        .load_o         (load),
        .load_fb_o      (load_fb),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .busy_o         (busy_o)
    );

    // result vector doubles as the feedback source
    analog_rx u_rx (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (en_i),
        .cfg_we_i      (cfg_we_i),
        .cmpt_cycles_i (cfg_cmpt_cycles_i),
        .load_i        (load),
        .load_fb_i     (load_fb),
        .host_spin_i   (host_spin_i),
        .fb_spin_i     (result_spin_o),
        .macro_spin_o  (macro_spin_o),
        .macro_start_o (macro_start_o),
        .cmpt_finish_o (cmpt_finish)
    );

    analog_tx u_tx (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (en_i),
        .cfg_we_i      (cfg_we_i),
        .sync_sel_i    (cfg_sync_sel_i),
        .sync_sel_o    (sync_sel_o),
        .macro_spin_i  (macro_spin_i),
        .cmpt_finish_i (cmpt_finish),
        .spin_valid_o  (spin_valid),
        .spin_ready_i  (spin_ready),
        .spin_o        (result_spin_o),
        .idle_o        (idle_o)
    );

endmodule

`default_nettype wire

// ==== verification/spin_if_props.sv ====
// spin interface timing properties
`default_nettype none

module spin_if_props
    import spin_if_pkg::*;
(
    input wire            clk_i,
    input wire            rst_n_i,
    input wire            en_i,
    input wire            load_i,
    input wire            macro_start_i,
    input wire            cmpt_finish_i,
    input wire            spin_valid_i,
    input wire sync_sel_t sync_sel_i,
    input wire            result_valid_i,
    input wire            result_ready_i,
    input wire spin_vec_t result_spin_i
);

    // bit k holds the finish pulse from k+1 cycles ago
    logic [SYNC_DEPTH:0] fin_hist;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !en_i) begin
            fin_hist <= '0;
        end else begin
            fin_hist <= {fin_hist[SYNC_DEPTH-1:0], cmpt_finish_i};
        end
    end

    capture_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i || !en_i)
        fin_hist[{1'b0, sync_sel_i} + 3'd1] |-> spin_valid_i)
        else $error("spin valid missing sync_sel+2 cycles after compute finish");

    result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || !en_i)
        (result_valid_i && !result_ready_i) |=> (result_valid_i && $stable(result_spin_i)))
        else $error("result dropped or changed before the handshake");

    start_after_load: assert property (@(posedge clk_i) disable iff (!rst_n_i || !en_i)
        load_i |=> macro_start_i)
        else $error("macro start missing one cycle after load");

endmodule

bind spin_if_top spin_if_props u_props (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .en_i           (en_i),
    .load_i         (load),
    .macro_start_i  (macro_start_o),
    .cmpt_finish_i  (cmpt_finish),
    .spin_valid_i   (spin_valid),
    .sync_sel_i     (sync_sel_o),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_spin_i  (result_spin_o)
);

`default_nettype wire

// ==== verification/spin_if_tb.sv ====
// spin interface testbench
`default_nettype none

module spin_if_tb
    import spin_if_pkg::*;
();

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        en_i;
    logic        cfg_we_i;
    sync_sel_t   cfg_sync_sel_i;
    cmpt_cnt_t   cfg_cmpt_cycles_i;
    iter_cnt_t   cfg_num_iter_i;
    sync_sel_t   sync_sel_o;
    logic        start_i;
    spin_vec_t   host_spin_i;
    logic        busy_o;
    logic        result_valid_o;
    logic        result_ready_i;
    spin_vec_t   result_spin_o;
    spin_vec_t   macro_spin_o;
    logic        macro_start_o;
    spin_vec_t   macro_spin_i = '0;
    logic        idle_o;

    logic [31:0] rng_state = 32'hec8c0300;
    int          cycle_cnt = 0;
    int          deadline = 100;
    int          start_cnt = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    sync_sel_t   cur_sel = 2'd3;
    cmpt_cnt_t   cur_cmpt = 8'd1;
    iter_cnt_t   cur_iter = 4'd1;
    spin_vec_t   exp_load = '0;

    spin_if_top dut_i (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        @(posedge clk_i);
        while (cycle_cnt < deadline) begin
            @(posedge clk_i);
        end
        $display("timeout, the DUT did not finish within %0d cycles", deadline);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_next(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // one compute step of the analog macro
    function automatic spin_vec_t macro_map(input spin_vec_t s);
        return {s[NUM_SPIN-2:0], s[NUM_SPIN-1]} ^ 16'h5a3c;
    endfunction

    function automatic spin_vec_t expected_result(input spin_vec_t host, input int iters);
        spin_vec_t s;
        s = host;
        for (int i = 0; i < iters; i++) begin
            s = macro_map(s);
        end
        return s;
    endfunction

    // macro model settles right after each start pulse
    always @(negedge clk_i) begin
        if (macro_start_o) begin
            check_spin("macro_spin_o", macro_spin_o, exp_load);
            macro_spin_i = macro_map(macro_spin_o);
            exp_load = macro_map(exp_load);
            start_cnt = start_cnt + 1;
        end
    end

    task automatic check_spin(input string name, input spin_vec_t got, input spin_vec_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input sync_sel_t got, input sync_sel_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        chk_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic configure(input sync_sel_t sel, input cmpt_cnt_t cmpt, input iter_cnt_t iter);
        deadline = cycle_cnt + 20;
        cfg_we_i = 1'b1;
        cfg_sync_sel_i = sel;
        cfg_cmpt_cycles_i = cmpt;
        cfg_num_iter_i = iter;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
        cur_sel = sel;
        cur_cmpt = cmpt;
        cur_iter = iter;
        check_sel("sync_sel_o", sync_sel_o, sel);
    endtask

    // full run with a random result stall and an optional start while busy
    task automatic run_check(input spin_vec_t host, input logic poke);
        int          iters;
        int          base;
        int          wait_cyc;
        int          stall;
        spin_vec_t   exp;
        logic [31:0] r;
        iters = (cur_iter == '0) ? 1 : int'(cur_iter);
        exp = expected_result(host, iters);
        base = start_cnt;
        rand_next(r);
        stall = int'(r[2:0]);
        deadline = cycle_cnt + 20 + iters * (int'(cur_cmpt) + int'(cur_sel) + 8);
        exp_load = host;
        start_i = 1'b1;
        host_spin_i = host;
        @(negedge clk_i);
        start_i = 1'b0;
        host_spin_i = r[31:16];
        check_flag("busy_o", busy_o, 1'b1);
        wait_cyc = 0;
        while (!result_valid_o) begin
            @(negedge clk_i);
            wait_cyc++;
            start_i = poke && (wait_cyc == 2);
        end
        start_i = 1'b0;
        check_spin("result_spin_o", result_spin_o, exp);
        repeat (stall) begin
            @(negedge clk_i);
            check_flag("result_valid_o", result_valid_o, 1'b1);
            check_flag("busy_o", busy_o, 1'b1);
            check_spin("result_spin_o", result_spin_o, exp);
        end
        result_ready_i = 1'b1;
        @(negedge clk_i);
        result_ready_i = 1'b0;
        check_flag("result_valid_o", result_valid_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("idle_o", idle_o, 1'b1);
        check_count("macro_start_o pulses", start_cnt - base, iters);
    endtask

    // enable drops somewhere inside a run
    task automatic abort_check(input spin_vec_t host);
        logic [31:0] r;
        rand_next(r);
        deadline = cycle_cnt + 40;
        exp_load = host;
        start_i = 1'b1;
        host_spin_i = host;
        @(negedge clk_i);
        start_i = 1'b0;
        repeat (int'(r[3:0]) + 1) @(negedge clk_i);
        en_i = 1'b0;
        repeat (2) begin
            @(negedge clk_i);
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("result_valid_o", result_valid_o, 1'b0);
            check_flag("idle_o", idle_o, 1'b1);
        end
        en_i = 1'b1;
        repeat (4) begin
            @(negedge clk_i);
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("result_valid_o", result_valid_o, 1'b0);
        end
    endtask

    initial begin
        logic [31:0] r;
        rst_n_i = 1'b0;
        en_i = 1'b1;
        cfg_we_i = 1'b0;
        cfg_sync_sel_i = '0;
        cfg_cmpt_cycles_i = '0;
        cfg_num_iter_i = '0;
        start_i = 1'b0;
        host_spin_i = '0;
        result_ready_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        check_sel("sync_sel_o", sync_sel_o, 2'd3);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("result_valid_o", result_valid_o, 1'b0);
        check_flag("idle_o", idle_o, 1'b1);

        // single iteration runs starting with a zero iteration count
        for (int i = 0; i < 6; i++) begin
            rand_next(r);
            configure(r[1:0], {3'b000, r[12:8]}, (i == 0) ? 4'd0 : 4'd1);
            rand_next(r);
            run_check(r[15:0], r[16]);
        end

        // multi iteration with feedback loads
        for (int i = 0; i < 6; i++) begin
            rand_next(r);
            configure(r[1:0], {4'b0000, r[11:8]}, 4'd2 + {1'b0, r[18:16]});
            rand_next(r);
            run_check(r[15:0], r[16]);
        end

        for (int i = 0; i < 3; i++) begin
            rand_next(r);
            abort_check(r[15:0]);
            rand_next(r);
            run_check(r[15:0], 1'b0);
        end

        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/spin_if_pkg.sv
logic/spin_synchronizer.sv
logic/analog_tx.sv
logic/analog_rx.sv
logic/spin_flow_ctrl.sv
logic/spin_if_top.sv
verification/spin_if_props.sv
verification/spin_if_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the spin interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module spin_if_tb -f filelist.f -o spin_if_sim

./obj_dir/spin_if_sim 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

# an aborted run never reaches the closing line
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
